//--- verilog/cpu_defs.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MIPS32 core definitions
// datapath width, register count and the
// address of the first instruction fetch
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// data and address width
`define CPU_XLEN 32

// architectural general purpose registers
`define CPU_NREGS 32

// boot rom vector
`define CPU_RESET_PC 32'hBFC00000

`endif

//--- verilog/cpu_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MIPS32 core types
// words, register numbers and the encodings
// shared by the decoder and the datapath
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "cpu_defs.svh"

package cpu_pkg;

    typedef logic [`CPU_XLEN-1:0] word_t;
    typedef logic [4:0]           reg_idx_t;

    // primary opcode field, instr[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,    // R-type, funct picks the op
        OP_J       = 6'h02,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SB      = 6'h28,
        OP_SW      = 6'h2b
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,               // signed compare
        ALU_LUI                // b shifted up by 16
    } alu_op_e;

    typedef enum logic {
        WB_ALU,
        WB_MEM                 // load data from the data sram
    } wb_sel_e;

    typedef enum logic [1:0] {
        FWD_REG,               // value read in ID
        FWD_MEM,               // result sitting in MEM
        FWD_WB                 // result sitting in WB
    } fwd_sel_e;

endpackage

//--- verilog/decoder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decode control unit
// turns an instruction word into the control
// signals carried down the pipeline
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "cpu_defs.svh"

module decoder import cpu_pkg::*; (
    input  word_t   instr_i,
    output alu_op_e alu_op_o,
    output logic    src_b_imm_o,
    output logic    imm_zero_ext_o,
    output logic    reg_wr_o,
    output logic    dst_rt_o,
    output logic    mem_rd_o,
    output logic    mem_wr_o,
    output logic    mem_byte_o,
    output logic    is_beq_o,
    output logic    is_bne_o,
    output logic    is_jump_o,
    output logic    uses_rs_o,
    output logic    uses_rt_o,
    output wb_sel_e wb_sel_o
);

    opcode_e    op;
    logic [5:0] funct;

    assign op    = opcode_e'(instr_i[`CPU_XLEN-1 -: 6]);
    assign funct = instr_i[5:0];

    always_comb begin
        alu_op_o       = ALU_ADD;
        src_b_imm_o    = 1'b0;
        imm_zero_ext_o = 1'b0;
        reg_wr_o       = 1'b0;
        dst_rt_o       = 1'b0;
        mem_rd_o       = 1'b0;
        mem_wr_o       = 1'b0;
        mem_byte_o     = 1'b0;
        is_beq_o       = 1'b0;
        is_bne_o       = 1'b0;
        is_jump_o      = 1'b0;
        uses_rs_o      = 1'b0;
        uses_rt_o      = 1'b0;
        wb_sel_o       = WB_ALU;

        case (op)
            OP_SPECIAL: begin
                reg_wr_o  = 1'b1;
                uses_rs_o = 1'b1;
                uses_rt_o = 1'b1;
                case (funct)
                    6'h21:   alu_op_o = ALU_ADD;   // addu
                    6'h23:   alu_op_o = ALU_SUB;   // subu
                    6'h24:   alu_op_o = ALU_AND;
                    6'h25:   alu_op_o = ALU_OR;
                    6'h26:   alu_op_o = ALU_XOR;
                    6'h2a:   alu_op_o = ALU_SLT;
                    default: begin                 // sll nop and unknown funct
                        reg_wr_o  = 1'b0;
                        uses_rs_o = 1'b0;
                        uses_rt_o = 1'b0;
                    end
                endcase
            end
            OP_ADDIU, OP_ORI, OP_LUI: begin
                src_b_imm_o    = 1'b1;
                reg_wr_o       = 1'b1;
                dst_rt_o       = 1'b1;
                imm_zero_ext_o = (op != OP_ADDIU);
                uses_rs_o      = (op != OP_LUI);
                alu_op_o       = (op == OP_ADDIU) ? ALU_ADD :
                                 (op == OP_ORI)   ? ALU_OR  : ALU_LUI;
            end
            OP_LW: begin
                src_b_imm_o = 1'b1;
                reg_wr_o    = 1'b1;
                dst_rt_o    = 1'b1;
                mem_rd_o    = 1'b1;
                uses_rs_o   = 1'b1;
                wb_sel_o    = WB_MEM;
            end
            OP_SW, OP_SB: begin
                src_b_imm_o = 1'b1;
                mem_wr_o    = 1'b1;
                mem_byte_o  = (op == OP_SB);
                uses_rs_o   = 1'b1;
                uses_rt_o   = 1'b1;            // store data
            end
            OP_BEQ, OP_BNE: begin
                alu_op_o  = ALU_SUB;
                is_beq_o  = (op == OP_BEQ);
                is_bne_o  = (op == OP_BNE);
                uses_rs_o = 1'b1;
                uses_rt_o = 1'b1;
            end
            OP_J:    is_jump_o = 1'b1;
            default: ;                         // treated as nop
        endcase
    end

    a_mem_excl: assert final (!(mem_rd_o && mem_wr_o))
        else $error("decoder: load and store decoded for one instruction");

endmodule

//--- verilog/reg_file.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register file
// two read ports, one write port, $zero
// hard wired, same-cycle write is seen by reads
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "cpu_defs.svh"

module reg_file import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n_i,
    input  reg_idx_t rs_i,
    input  reg_idx_t rt_i,
    input  reg_idx_t wr_idx_i,
    input  logic     wr_en_i,
    input  word_t    wr_data_i,
    output word_t    rs_data_o,
    output word_t    rt_data_o
);

    word_t regs [`CPU_NREGS];

    // read with WB bypass, so ID sees the value retiring this cycle
    function automatic word_t read_port(reg_idx_t idx);
        if (idx == '0)
            return '0;
        if (wr_en_i && wr_idx_i == idx)
            return wr_data_i;
        return regs[idx];
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `CPU_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i && wr_idx_i != '0) begin
            regs[wr_idx_i] <= wr_data_i;
        end
    end

    assign rs_data_o = read_port(rs_i);
    assign rt_data_o = read_port(rt_i);

endmodule

//--- verilog/alu.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ALU
// add, sub, logic ops, signed slt and lui,
// plus operand equality for branches
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module alu import cpu_pkg::*; (
    input  alu_op_e op_i,
    input  word_t   a_i,
    input  word_t   b_i,
    output word_t   y_o,
    output logic    eq_o
);

    always_comb begin
        case (op_i)
            ALU_ADD: y_o = a_i + b_i;      // no overflow trap
            ALU_SUB: y_o = a_i - b_i;
            ALU_AND: y_o = a_i & b_i;
            ALU_OR:  y_o = a_i | b_i;
            ALU_XOR: y_o = a_i ^ b_i;
            ALU_SLT: y_o = word_t'($signed(a_i) < $signed(b_i));
            ALU_LUI: y_o = b_i << 16;
            default: y_o = '0;
        endcase
    end

    assign eq_o = (a_i == b_i);            // beq/bne compare

endmodule

//--- verilog/hazard_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Hazard unit
// EXE operand forwarding, load-use stall
// and fetch flush on a taken branch
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module hazard_unit import cpu_pkg::*; (
    input  reg_idx_t id_rs_i,
    input  reg_idx_t id_rt_i,
    input  reg_idx_t ex_rs_i,
    input  reg_idx_t ex_rt_i,
    input  reg_idx_t ex_dst_i,
    input  reg_idx_t mem_dst_i,
    input  reg_idx_t wb_dst_i,
    input  logic     id_uses_rs_i,
    input  logic     id_uses_rt_i,
    input  logic     ex_mem_rd_i,
    input  logic     mem_reg_wr_i,
    input  logic     wb_reg_wr_i,
    input  logic     ex_branch_taken_i,
    output fwd_sel_e fwd_a_o,
    output fwd_sel_e fwd_b_o,
    output logic     stall_o,
    output logic     flush_o
);

    logic load_hits_rs;
    logic load_hits_rt;

    // youngest writer wins, $zero is never forwarded
    function automatic fwd_sel_e pick_src(reg_idx_t src);
        if (src == '0)
            return FWD_REG;
        if (mem_reg_wr_i && mem_dst_i == src)
            return FWD_MEM;
        if (wb_reg_wr_i && wb_dst_i == src)
            return FWD_WB;
        return FWD_REG;
    endfunction

    assign fwd_a_o = pick_src(ex_rs_i);
    assign fwd_b_o = pick_src(ex_rt_i);

    assign load_hits_rs = id_uses_rs_i && id_rs_i == ex_dst_i;
    assign load_hits_rt = id_uses_rt_i && id_rt_i == ex_dst_i;

    // load data only exists in WB, so the user waits one cycle
    assign stall_o = ex_mem_rd_i && ex_dst_i != '0 && (load_hits_rs || load_hits_rt);
    assign flush_o = ex_branch_taken_i;    // kills the word after the delay slot

    // a branch in EXE is never a load, so the two cannot meet
    a_stall_flush: assert final (!(stall_o && flush_o))
        else $error("hazard_unit: stall and flush in the same cycle");

endmodule

//--- verilog/mycpu_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// mycpu_top
// five stage in-order MIPS32 pipeline with
// instruction and data SRAM ports and a
// writeback debug trace
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "cpu_defs.svh"

module mycpu_top import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n_i,

    output logic     inst_sram_en_o,
    output logic [3:0] inst_sram_wen_o,
    output word_t    inst_sram_addr_o,
    output word_t    inst_sram_wdata_o,
    input  word_t    inst_sram_rdata_i,

    output logic     data_sram_en_o,
    output logic [3:0] data_sram_wen_o,
    output word_t    data_sram_addr_o,
    output word_t    data_sram_wdata_o,
    input  word_t    data_sram_rdata_i,

    output word_t    debug_wb_pc_o,
    output logic [3:0] debug_wb_rf_wen_o,
    output reg_idx_t debug_wb_rf_wnum_o,
    output word_t    debug_wb_rf_wdata_o
);

    // IF
    word_t    pc_q;
    word_t    next_pc;

    // ID
    logic     id_valid_q;
    word_t    id_pc_q;
    word_t    id_instr_q;
    reg_idx_t id_rs, id_rt, id_rd;
    word_t    id_imm;
    word_t    id_rs_data, id_rt_data;
    word_t    jump_target;
    logic     id_jump;
    alu_op_e  d_alu_op;
    wb_sel_e  d_wb_sel;
    logic     d_src_b_imm, d_imm_zero_ext, d_reg_wr, d_dst_rt;
    logic     d_mem_rd, d_mem_wr, d_mem_byte;
    logic     d_is_beq, d_is_bne, d_is_jump, d_uses_rs, d_uses_rt;

    // EX
    logic     ex_valid_q;
    word_t    ex_pc_q, ex_imm_q, ex_rs_data_q, ex_rt_data_q;
    reg_idx_t ex_rs_q, ex_rt_q, ex_dst_q;
    alu_op_e  ex_alu_op_q;
    wb_sel_e  ex_wb_sel_q;
    logic     ex_src_b_imm_q, ex_reg_wr_q, ex_mem_rd_q, ex_mem_wr_q;
    logic     ex_mem_byte_q, ex_is_beq_q, ex_is_bne_q;
    fwd_sel_e fwd_a, fwd_b;
    word_t    ex_a, ex_b_reg, ex_b, ex_y;
    logic     ex_eq;
    logic     br_taken;
    word_t    br_target;

    // MEM
    logic     mem_valid_q;
    word_t    mem_pc_q, mem_alu_q, mem_store_q;
    reg_idx_t mem_dst_q;
    wb_sel_e  mem_wb_sel_q;
    logic     mem_reg_wr_q, mem_mem_rd_q, mem_mem_wr_q, mem_byte_q;
    logic     mem_we;

    // WB
    logic     wb_valid_q;
    word_t    wb_pc_q, wb_alu_q, wb_result;
    reg_idx_t wb_dst_q;
    wb_sel_e  wb_sel_q;
    logic     wb_reg_wr_q;
    logic     wb_we;

    logic     stall, flush;

    // next PC, branch beats jump; a stall refetches the current word
    always_comb begin
        if (stall)
            next_pc = pc_q;
        else if (br_taken)
            next_pc = br_target;
        else if (id_jump)
            next_pc = jump_target;
        else
            next_pc = pc_q + 32'd4;
    end

    // reset vector is fetched while in reset, so its word is in IF on release
    assign inst_sram_addr_o  = rst_n_i ? next_pc : `CPU_RESET_PC;
    assign inst_sram_en_o    = 1'b1;       // srams never push back
    assign inst_sram_wen_o   = 4'b0000;
    assign inst_sram_wdata_o = '0;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_q        <= `CPU_RESET_PC;
            id_valid_q  <= 1'b0;
            ex_valid_q  <= 1'b0;
            mem_valid_q <= 1'b0;
            wb_valid_q  <= 1'b0;
        end else begin
            pc_q <= next_pc;
            if (!stall) begin
                id_valid_q <= ~flush;      // taken branch drops the IF word
            end
            ex_valid_q  <= id_valid_q & ~stall;   // bubble on load-use
            mem_valid_q <= ex_valid_q;
            wb_valid_q  <= mem_valid_q;
        end
    end

    // IF/ID
    always_ff @(posedge clk) begin
        if (!stall) begin
            id_instr_q <= inst_sram_rdata_i;
            id_pc_q    <= pc_q;
        end
    end

    assign id_rs = id_instr_q[25:21];
    assign id_rt = id_instr_q[20:16];
    assign id_rd = id_instr_q[15:11];
    assign id_imm = d_imm_zero_ext ? {16'h0, id_instr_q[15:0]}
                                   : {{16{id_instr_q[15]}}, id_instr_q[15:0]};
    assign id_jump     = id_valid_q & d_is_jump;
    assign jump_target = {pc_q[31:28], id_instr_q[25:0], 2'b00};  // pc_q is the delay slot

    decoder u_decoder (
        .instr_i        (id_instr_q),
        .alu_op_o       (d_alu_op),
        .src_b_imm_o    (d_src_b_imm),
        .imm_zero_ext_o (d_imm_zero_ext),
        .reg_wr_o       (d_reg_wr),
        .dst_rt_o       (d_dst_rt),
        .mem_rd_o       (d_mem_rd),
        .mem_wr_o       (d_mem_wr),
        .mem_byte_o     (d_mem_byte),
        .is_beq_o       (d_is_beq),
        .is_bne_o       (d_is_bne),
        .is_jump_o      (d_is_jump),
        .uses_rs_o      (d_uses_rs),
        .uses_rt_o      (d_uses_rt),
        .wb_sel_o       (d_wb_sel)
    );

    reg_file u_reg_file (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .rs_i      (id_rs),
        .rt_i      (id_rt),
        .wr_idx_i  (wb_dst_q),
        .wr_en_i   (wb_we),
        .wr_data_i (wb_result),
        .rs_data_o (id_rs_data),
        .rt_data_o (id_rt_data)
    );

    hazard_unit u_hazard_unit (
        .id_rs_i           (id_rs),
        .id_rt_i           (id_rt),
        .ex_rs_i           (ex_rs_q),
        .ex_rt_i           (ex_rt_q),
        .ex_dst_i          (ex_dst_q),
        .mem_dst_i         (mem_dst_q),
        .wb_dst_i          (wb_dst_q),
        .id_uses_rs_i      (id_valid_q & d_uses_rs),
        .id_uses_rt_i      (id_valid_q & d_uses_rt),
        .ex_mem_rd_i       (ex_valid_q & ex_mem_rd_q),
        .mem_reg_wr_i      (mem_we),
        .wb_reg_wr_i       (wb_we),
        .ex_branch_taken_i (br_taken),
        .fwd_a_o           (fwd_a),
        .fwd_b_o           (fwd_b),
        .stall_o           (stall),
        .flush_o           (flush)
    );

    // ID/EX
    always_ff @(posedge clk) begin
        ex_pc_q        <= id_pc_q;
        ex_imm_q       <= id_imm;
        ex_rs_data_q   <= id_rs_data;
        ex_rt_data_q   <= id_rt_data;
        ex_rs_q        <= id_rs;
        ex_rt_q        <= id_rt;
        ex_dst_q       <= d_dst_rt ? id_rt : id_rd;
        ex_alu_op_q    <= d_alu_op;
        ex_wb_sel_q    <= d_wb_sel;
        ex_src_b_imm_q <= d_src_b_imm;
        ex_reg_wr_q    <= d_reg_wr;
        ex_mem_rd_q    <= d_mem_rd;
        ex_mem_wr_q    <= d_mem_wr;
        ex_mem_byte_q  <= d_mem_byte;
        ex_is_beq_q    <= d_is_beq;
        ex_is_bne_q    <= d_is_bne;
    end

    function automatic word_t fwd_mux(fwd_sel_e sel, word_t reg_val);
        case (sel)
            FWD_MEM: return mem_alu_q;
            FWD_WB:  return wb_result;
            default: return reg_val;
        endcase
    endfunction

    assign ex_a     = fwd_mux(fwd_a, ex_rs_data_q);
    assign ex_b_reg = fwd_mux(fwd_b, ex_rt_data_q);    // also the store data
    assign ex_b     = ex_src_b_imm_q ? ex_imm_q : ex_b_reg;

    alu u_alu (
        .op_i (ex_alu_op_q),
        .a_i  (ex_a),
        .b_i  (ex_b),
        .y_o  (ex_y),
        .eq_o (ex_eq)
    );

    assign br_taken  = ex_valid_q & ((ex_is_beq_q & ex_eq) | (ex_is_bne_q & ~ex_eq));
    assign br_target = ex_pc_q + 32'd4 + {ex_imm_q[29:0], 2'b00};

    // EX/MEM
    always_ff @(posedge clk) begin
        mem_pc_q     <= ex_pc_q;
        mem_alu_q    <= ex_y;
        mem_store_q  <= ex_b_reg;
        mem_dst_q    <= ex_dst_q;
        mem_wb_sel_q <= ex_wb_sel_q;
        mem_reg_wr_q <= ex_reg_wr_q;
        mem_mem_rd_q <= ex_mem_rd_q;
        mem_mem_wr_q <= ex_mem_wr_q;
        mem_byte_q   <= ex_mem_byte_q;
    end

    assign mem_we = mem_valid_q & mem_reg_wr_q;

    assign data_sram_en_o    = mem_valid_q & (mem_mem_rd_q | mem_mem_wr_q);
    assign data_sram_addr_o  = mem_alu_q;
    assign data_sram_wen_o   = !(mem_valid_q && mem_mem_wr_q) ? 4'b0000 :
                               mem_byte_q ? (4'b0001 << mem_alu_q[1:0]) : 4'b1111;
    assign data_sram_wdata_o = mem_byte_q ? {4{mem_store_q[7:0]}} : mem_store_q;

    // MEM/WB
    always_ff @(posedge clk) begin
        wb_pc_q     <= mem_pc_q;
        wb_alu_q    <= mem_alu_q;
        wb_dst_q    <= mem_dst_q;
        wb_sel_q    <= mem_wb_sel_q;
        wb_reg_wr_q <= mem_reg_wr_q;
    end

    assign wb_we     = wb_valid_q & wb_reg_wr_q;
    assign wb_result = (wb_sel_q == WB_MEM) ? data_sram_rdata_i : wb_alu_q;  // lw data arrives now

    assign debug_wb_pc_o       = wb_pc_q;
    assign debug_wb_rf_wen_o   = (wb_we && wb_dst_q != '0) ? 4'b1111 : 4'b0000;
    assign debug_wb_rf_wnum_o  = wb_dst_q;
    assign debug_wb_rf_wdata_o = wb_result;

    a_wen_needs_en: assert property (@(posedge clk) disable iff (!rst_n_i)
        (data_sram_wen_o != 4'b0000) |-> data_sram_en_o)
        else $error("mycpu_top: data sram byte enables without en");

endmodule

//--- sim/tb_mycpu.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for mycpu_top
// random program against an ISA model,
// trace and data memory compared
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "cpu_defs.svh"

module tb_mycpu import cpu_pkg::*; ();

    localparam int    PROG_LEN     = 200;
    localparam int    RESET_CYCLES = 8;
    localparam int    CLK_PERIOD   = 4;
    localparam word_t FINAL_PC     = `CPU_RESET_PC + 4 * (PROG_LEN - 2);

    logic       clk;
    logic       rst_n;
    logic       inst_en, data_en;
    logic [3:0] inst_wen, data_wen, wb_wen;
    word_t      inst_addr, inst_wdata, inst_rdata;
    word_t      data_addr, data_wdata, data_rdata;
    word_t      wb_pc, wb_wdata;
    reg_idx_t   wb_wnum;

    word_t       imem [256];
    word_t       dmem [256];
    word_t       ref_mem [256];
    word_t       exp_pc [$];
    reg_idx_t    exp_reg [$];
    word_t       exp_val [$];
    int          wb_count = 0;
    logic [31:0] rng_state = 32'h3b01_8b65;

    mycpu_top u_mycpu_top (
        .clk                 (clk),
        .rst_n_i             (rst_n),
        .inst_sram_en_o      (inst_en),
        .inst_sram_wen_o     (inst_wen),
        .inst_sram_addr_o    (inst_addr),
        .inst_sram_wdata_o   (inst_wdata),
        .inst_sram_rdata_i   (inst_rdata),
        .data_sram_en_o      (data_en),
        .data_sram_wen_o     (data_wen),
        .data_sram_addr_o    (data_addr),
        .data_sram_wdata_o   (data_wdata),
        .data_sram_rdata_i   (data_rdata),
        .debug_wb_pc_o       (wb_pc),
        .debug_wb_rf_wen_o   (wb_wen),
        .debug_wb_rf_wnum_o  (wb_wnum),
        .debug_wb_rf_wdata_o (wb_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // sram models, read data valid the cycle after en
    always @(posedge clk) begin
        if (inst_en)
            inst_rdata <= imem[inst_addr[9:2]];
    end

    always @(posedge clk) begin
        if (data_en) begin
            for (int b = 0; b < 4; b++) begin
                if (data_wen[b])
                    dmem[data_addr[9:2]][8*b +: 8] <= data_wdata[8*b +: 8];
            end
            data_rdata <= dmem[data_addr[9:2]];
        end
    end

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand_next();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic word_t data_fill(int idx);
        word_t a;
        a = word_t'(idx) << 2;
        return (a * 32'h9e37_79b9) ^ {a[15:0], ~a[15:0]};
    endfunction

    function automatic word_t enc_r(logic [5:0] funct, reg_idx_t rs, reg_idx_t rt, reg_idx_t rd);
        return {6'h00, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic word_t enc_i(opcode_e op, reg_idx_t rs, reg_idx_t rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [5:0] alu_funct(logic [2:0] n);
        case (n)
            3'd0:    return 6'h21;    // addu
            3'd1:    return 6'h23;    // subu
            3'd2:    return 6'h24;    // and
            3'd3:    return 6'h25;    // or
            3'd4:    return 6'h26;    // xor
            default: return 6'h2a;    // slt
        endcase
    endfunction

    // mostly the last three destinations, so forwarding and load-use get hit
    function automatic reg_idx_t pick_src(reg_idx_t h0, reg_idx_t h1, reg_idx_t h2);
        logic [31:0] r;
        r = rand_next();
        case (r[2:0])
            3'd0, 3'd1: return h0;
            3'd2:       return h1;
            3'd3:       return h2;
            default:    return reg_idx_t'(1 + r[10:8]);
        endcase
    endfunction

    function automatic reg_idx_t pick_dst();
        logic [31:0] r;
        r = rand_next();
        return (r[7:4] == 4'd0) ? 5'd0 : reg_idx_t'(1 + r[2:0]);   // sometimes $zero
    endfunction

    task automatic build_program();
        logic [31:0] r;
        logic [3:0]  kind;
        reg_idx_t    rs, rt, dst, h0, h1, h2;
        int          span, tgt;
        logic        prev_ctrl;
        prev_ctrl = 1'b0;
        for (int i = 0; i < 256; i++)
            imem[i] = {18'h0, 8'(i), 6'h00};        // sll nop, index in rd and shamt
        imem[0] = enc_i(OP_LUI, 5'd0, 5'd1, 16'h8001);
        h0 = 5'd1;
        h1 = 5'd0;
        h2 = 5'd0;
        for (int i = 1; i < PROG_LEN - 2; i++) begin
            r    = rand_next();
            rs   = pick_src(h0, h1, h2);
            rt   = pick_src(h0, h1, h2);
            dst  = pick_dst();
            kind = r[3:0];
            if (kind >= 4'd13 && (prev_ctrl || i > PROG_LEN - 4))
                kind = 4'd6;                         // no control in a delay slot
            case (kind)
                0, 1, 2, 3, 4, 5: imem[i] = enc_r(alu_funct(3'(r[31:16] % 6)), rs, rt, dst);
                6:  imem[i] = enc_i(OP_ADDIU, rs, dst, r[31:16]);
                7:  imem[i] = enc_i(OP_ORI, rs, dst, r[31:16]);
                8:  imem[i] = enc_i(OP_LUI, 5'd0, dst, r[31:16]);
                9, 10: imem[i] = enc_i(OP_LW, 5'd0, dst, {8'h0, r[23:18], 2'b00});
                11, 12: begin
                    dst = 5'd0;
                    if (kind == 4'd11)
                        imem[i] = enc_i(OP_SW, 5'd0, rt, {8'h0, r[23:18], 2'b00});
                    else
                        imem[i] = enc_i(OP_SB, 5'd0, rt, {8'h0, r[23:16]});
                end
                13, 14: begin
                    dst  = 5'd0;
                    span = (PROG_LEN - 2) - (i + 2) + 1;
                    span = (span > 8) ? 8 : span;
                    tgt  = i + 2 + int'(r[31:16]) % span;
                    if (r[5:4] == 2'd0)
                        rt = rs;                     // forces the compare equal
                    imem[i] = enc_i((kind == 4'd13) ? OP_BEQ : OP_BNE, rs, rt,
                                    16'(tgt - (i + 1)));
                end
                default: begin
                    dst  = 5'd0;
                    span = (PROG_LEN - 2) - (i + 2) + 1;
                    span = (span > 16) ? 16 : span;
                    tgt  = i + 2 + int'(r[31:16]) % span;
                    imem[i] = {OP_J, 26'((`CPU_RESET_PC + 4 * tgt) >> 2)};
                end
            endcase
            prev_ctrl = (kind >= 4'd13);
            h2 = h1;
            h1 = h0;
            h0 = dst;
        end
        imem[PROG_LEN-2] = {OP_J, 26'(FINAL_PC >> 2)};   // park here
        imem[PROG_LEN-1] = 32'h0;
    endtask

    // architectural model with delay slots
    function automatic void run_reference();
        word_t    regs [32];
        word_t    pc, npc, nnpc, instr, a, b, simm, zimm, addr, res;
        reg_idx_t rs, rt, dst;
        logic     wr;
        for (int k = 0; k < 32; k++)
            regs[k] = '0;
        for (int k = 0; k < 256; k++)
            ref_mem[k] = data_fill(k);
        pc  = `CPU_RESET_PC;
        npc = pc + 4;
        while (pc != FINAL_PC) begin
            instr = imem[pc[9:2]];
            rs    = instr[25:21];
            rt    = instr[20:16];
            a     = regs[rs];
            b     = regs[rt];
            simm  = {{16{instr[15]}}, instr[15:0]};
            zimm  = {16'h0, instr[15:0]};
            addr  = a + simm;
            nnpc  = npc + 4;
            wr    = 1'b0;
            dst   = rt;
            res   = '0;
            case (instr[31:26])
                OP_SPECIAL: begin
                    dst = instr[15:11];
                    wr  = 1'b1;
                    case (instr[5:0])
                        6'h21:   res = a + b;
                        6'h23:   res = a - b;
                        6'h24:   res = a & b;
                        6'h25:   res = a | b;
                        6'h26:   res = a ^ b;
                        6'h2a:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: wr = 1'b0;
                    endcase
                end
                OP_ADDIU: {wr, res} = {1'b1, a + simm};
                OP_ORI:   {wr, res} = {1'b1, a | zimm};
                OP_LUI:   {wr, res} = {1'b1, instr[15:0], 16'h0};
                OP_LW:    {wr, res} = {1'b1, ref_mem[addr[9:2]]};
                OP_SW:    ref_mem[addr[9:2]] = b;
                OP_SB:    ref_mem[addr[9:2]][8*addr[1:0] +: 8] = b[7:0];
                OP_BEQ:   nnpc = (a == b) ? npc + (simm << 2) : nnpc;
                OP_BNE:   nnpc = (a != b) ? npc + (simm << 2) : nnpc;
                OP_J:     nnpc = {npc[31:28], instr[25:0], 2'b00};
                default:  wr = 1'b0;
            endcase
            if (wr && dst != '0) begin
                regs[dst] = res;
                exp_pc.push_back(pc);
                exp_reg.push_back(dst);
                exp_val.push_back(res);
            end
            pc  = npc;
            npc = nnpc;
        end
    endfunction

    task automatic end_in_failure();
        $display("=== FAIL ===");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic report_error(string msg);
        $display("ERR @%0t: %s", $time, msg);
        end_in_failure();
    endtask

    task automatic check_word(string what, word_t got, word_t exp);
        if (got !== exp)
            report_error($sformatf("%s is %h, expected %h", what, got, exp));
    endtask

    task automatic check_wb(word_t pc, reg_idx_t num, word_t val);
        if (wb_count >= exp_pc.size())
            report_error($sformatf("extra write r%0d = %h at pc %h", num, val, pc));
        else if (pc !== exp_pc[wb_count] || num !== exp_reg[wb_count] ||
                 val !== exp_val[wb_count])
            report_error($sformatf("write %0d is pc %h r%0d = %h, expected pc %h r%0d = %h",
                                   wb_count, pc, num, val, exp_pc[wb_count],
                                   exp_reg[wb_count], exp_val[wb_count]));
        wb_count++;
    endtask

    task automatic check_mem(int idx, word_t got, word_t exp);
        if (got !== exp)
            report_error($sformatf("data word %0d is %h, expected %h", idx, got, exp));
    endtask

    // trace compare, sampled away from the rising edge
    always @(negedge clk) begin
        check_word("inst sram wen", word_t'(inst_wen), '0);
        check_word("inst sram wdata", inst_wdata, '0);
        if (!rst_n) begin
            check_word("data sram en in reset", word_t'(data_en), '0);
            check_word("data sram wen in reset", word_t'(data_wen), '0);
            check_word("trace wen in reset", word_t'(wb_wen), '0);
        end else begin
            check_word("inst sram en", word_t'(inst_en), 32'd1);
            if (wb_wen != 4'b0000) begin
                check_word("trace wen", word_t'(wb_wen), 32'h0000_000f);
                check_wb(wb_pc, wb_wnum, wb_wdata);
            end
        end
    end

    initial begin
        #(CLK_PERIOD * (8 * PROG_LEN + RESET_CYCLES));
        $display("timeout: the program did not reach its end within %0d cycles",
                 8 * PROG_LEN + RESET_CYCLES);
        end_in_failure();
    end

    initial begin
        rst_n      = 1'b0;
        inst_rdata = '0;
        data_rdata = '0;
        build_program();
        for (int k = 0; k < 256; k++)
            dmem[k] = data_fill(k);
        run_reference();
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_word("first fetch address", inst_addr, `CPU_RESET_PC + 32'd4);
        check_word("data sram en after reset", word_t'(data_en), '0);
        while (wb_count < exp_pc.size() || inst_addr != FINAL_PC)
            @(negedge clk);
        repeat (6) @(negedge clk);   // drain stores behind the last write
        for (int k = 0; k < 256; k++)
            check_mem(k, dmem[k], ref_mem[k]);
        $display("=== PASS ===");
        $finish;
    end

endmodule

//--- filelist.f
+incdir+verilog
verilog/cpu_pkg.sv
verilog/decoder.sv
verilog/reg_file.sv
verilog/alu.sv
verilog/hazard_unit.sv
verilog/mycpu_top.sv
sim/tb_mycpu.sv
